//--- hdl/dcache_pkg.sv
// Data cache shared definitions
`default_nettype none

package dcache_pkg;

   // ********************
   // Geometry
   // ********************

   // Byte address and data word
   localparam int ADR_W    = 16;
   localparam int DAT_W    = 32;
   // 16-byte lines, 16 sets, two ways
   localparam int BLOCK_W  = 4;
   localparam int SET_W    = 4;
   localparam int WORD_W   = BLOCK_W - 2;
   localparam int TAG_W    = ADR_W - BLOCK_W - SET_W;
   localparam int NUM_WAYS = 2;

   // Address fields and payloads
   typedef logic [SET_W-1:0]    set_idx_t;
   typedef logic [WORD_W-1:0]   word_idx_t;
   typedef logic [TAG_W-1:0]    tag_t;
   typedef logic [DAT_W-1:0]    word_t;
   typedef logic [DAT_W/8-1:0]  bsel_t;
   // One-hot, bit n selects way n
   typedef logic [NUM_WAYS-1:0] way_sel_t;

   // ********************
   // Tag RAM entries
   // ********************

   typedef struct packed {
      logic valid;
      logic dirty;
      tag_t tag;
   } tag_entry_t;

   // Both ways of one set share a RAM word
   typedef struct packed {
      tag_entry_t [NUM_WAYS-1:0] way;
   } set_entry_t;

   // Controller FSM
   typedef enum logic [2:0] {IDLE, LOOKUP, WRITE, DUMP, REFILL, DONE} ctrl_state_t;

endpackage

`default_nettype wire

//--- hdl/dcache_ifs.sv
// Data cache internal interfaces
`timescale 1ns/1ps
`default_nettype none

// Controller to tag store
interface tag_if;
   import dcache_pkg::*;

   set_idx_t set;
   tag_t     tag;
   logic     mark_dirty;
   logic     touch;
   logic     fill;
   way_sel_t fill_way;
   way_sel_t hit_way;
   way_sel_t victim_way;
   logic     victim_dirty;
   tag_t     victim_tag;
   // High while the tag RAM is being cleared after reset
   logic     busy;

   modport ctrl (output set, tag, mark_dirty, touch, fill, fill_way,
                 input  hit_way, victim_way, victim_dirty, victim_tag, busy);
   modport store (input  set, tag, mark_dirty, touch, fill, fill_way,
                  output hit_way, victim_way, victim_dirty, victim_tag, busy);
endinterface

// Controller to data store
interface data_if;
   import dcache_pkg::*;

   set_idx_t  set;
   word_idx_t word;
   way_sel_t  way;
   logic      we;
   bsel_t     bsel;
   word_t     wdata;
   // Registered read, one cycle behind set and word
   word_t     rdata;

   modport ctrl (output set, word, way, we, bsel, wdata, input rdata);
   modport store (input set, word, way, we, bsel, wdata, output rdata);
endinterface

// Controller to line mover
interface xfer_if;
   import dcache_pkg::*;

   logic                   start;
   logic                   dump;
   logic [ADR_W-BLOCK_W-1:0] line_adr;
   word_t                  wdata;
   word_idx_t              word_idx;
   logic                   word_strobe;
   word_t                  rdata;
   logic                   done;

   modport ctrl (output start, dump, line_adr, wdata,
                 input  word_idx, word_strobe, rdata, done);
   modport mover (input  start, dump, line_adr, wdata,
                  output word_idx, word_strobe, rdata, done);
endinterface

`default_nettype wire

//--- hdl/sync_ram.sv
// Single-clock dual-port RAM
`timescale 1ns/1ps
`default_nettype none

module sync_ram #(
   parameter type entry_t = logic [31:0],
   parameter int  ADDR_W  = 4
) (
   input  logic              clk,
   input  logic [ADDR_W-1:0] raddr_i,
   output entry_t            rdata_o,
   input  logic [ADDR_W-1:0] waddr_i,
   input  logic              we_i,
   input  entry_t            wdata_i
);

   entry_t mem [2**ADDR_W];

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
      // Write-first, new data shows on a same-address read
      if (we_i && (waddr_i == raddr_i)) begin
         rdata_o <= wdata_i;
      end else begin
         rdata_o <= mem[raddr_i];
      end
   end

endmodule

`default_nettype wire

//--- hdl/tag_store.sv
// Tag store with LRU
`timescale 1ns/1ps
`default_nettype none

module tag_store #(
   parameter int SET_W_P = dcache_pkg::SET_W
) (
   input  logic  clk,
   input  logic  rst,
   tag_if.store  tag_p
);
   import dcache_pkg::*;

   set_entry_t         rd_entry;
   set_entry_t         wr_entry;
   logic               wr_en;
   logic [SET_W_P-1:0] waddr;
   logic [SET_W_P-1:0] sweep_cnt_q;
   logic               sweep_q;
   // One bit per set, names the LRU way
   logic [2**SET_W_P-1:0] lru_q;
   way_sel_t           hit;
   tag_entry_t         victim;

   sync_ram #(
      .entry_t (set_entry_t),
      .ADDR_W  (SET_W_P)
   ) u_tag_ram (
      .clk     (clk),
      .raddr_i (tag_p.set),
      .rdata_o (rd_entry),
      .waddr_i (waddr),
      .we_i    (wr_en),
      .wdata_i (wr_entry)
   );

   // ********************
   // Lookup
   // ********************

   always_comb begin
      for (int w = 0; w < NUM_WAYS; w++) begin
         hit[w] = !sweep_q && rd_entry.way[w].valid && (rd_entry.way[w].tag == tag_p.tag);
      end
   end

   assign victim             = rd_entry.way[lru_q[tag_p.set]];
   assign tag_p.hit_way      = hit;
   assign tag_p.victim_way   = lru_q[tag_p.set] ? way_sel_t'(2'b10) : way_sel_t'(2'b01);
   // Only a valid line needs write-back
   assign tag_p.victim_dirty = victim.valid && victim.dirty;
   assign tag_p.victim_tag   = victim.tag;
   assign tag_p.busy         = sweep_q;

   // ********************
   // Update
   // ********************

   // Read-modify-write of the whole set entry
   always_comb begin
      wr_entry = rd_entry;
      for (int w = 0; w < NUM_WAYS; w++) begin
         if (tag_p.mark_dirty && hit[w]) begin
            wr_entry.way[w].dirty = 1'b1;
         end
         if (tag_p.fill && tag_p.fill_way[w]) begin
            wr_entry.way[w].valid = 1'b1;
            wr_entry.way[w].dirty = 1'b0;
            wr_entry.way[w].tag   = tag_p.tag;
         end
      end
      // Sweep clears both ways
      if (sweep_q) begin
         wr_entry = '0;
      end
   end

   assign wr_en = sweep_q || tag_p.mark_dirty || tag_p.fill;
   assign waddr = sweep_q ? sweep_cnt_q : tag_p.set;

   // Sweep walks every set once after reset
   always_ff @(posedge clk) begin
      if (rst) begin
         sweep_q     <= 1'b1;
         sweep_cnt_q <= '0;
      end else if (sweep_q) begin
         sweep_cnt_q <= sweep_cnt_q + 1'b1;
         if (&sweep_cnt_q) begin
            sweep_q <= 1'b0;
         end
      end
   end

   // Accessed way becomes MRU, so the other way is next victim
   always_ff @(posedge clk) begin
      if (rst) begin
         lru_q <= '0;
      end else if (tag_p.touch) begin
         lru_q[tag_p.set] <= hit[0];
      end
   end

   // Refill only fills on a miss, so a tag never lives in both ways
   assert property (@(posedge clk) disable iff (rst) $onehot0(hit))
      else $error("tag hit in both ways of set %0h", tag_p.set);

endmodule

`default_nettype wire

//--- hdl/data_store.sv
// Data store with byte merge
`timescale 1ns/1ps
`default_nettype none

module data_store #(
   parameter int SET_W_P   = dcache_pkg::SET_W,
   parameter int BLOCK_W_P = dcache_pkg::BLOCK_W
) (
   input  logic  clk,
   data_if.store data_p
);
   import dcache_pkg::*;

   // Word address within one way
   localparam int RAM_AW = SET_W_P + BLOCK_W_P - 2;

   logic [RAM_AW-1:0] addr;
   word_t             rd_way [NUM_WAYS];
   word_t             old_word;
   word_t             new_word;

   assign addr = {data_p.set, data_p.word};

   // Selected way, read and write use the same one
   assign old_word     = data_p.way[1] ? rd_way[1] : rd_way[0];
   assign data_p.rdata = old_word;

   // Enabled bytes from the write data, the rest kept
   always_comb begin
      for (int b = 0; b < DAT_W/8; b++) begin
         new_word[8*b +: 8] = data_p.bsel[b] ? data_p.wdata[8*b +: 8] : old_word[8*b +: 8];
      end
   end

   // ********************
   // Way RAMs
   // ********************

   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
      sync_ram #(
         .entry_t (word_t),
         .ADDR_W  (RAM_AW)
      ) u_way_ram (
         .clk     (clk),
         .raddr_i (addr),
         .rdata_o (rd_way[w]),
         .waddr_i (addr),
         .we_i    (data_p.we && data_p.way[w]),
         .wdata_i (new_word)
      );
   end

endmodule

`default_nettype wire

//--- hdl/line_mover.sv
// Line transfer engine
`timescale 1ns/1ps
`default_nettype none

module line_mover #(
   parameter int BLOCK_W_P = dcache_pkg::BLOCK_W
) (
   input  logic                         clk,
   input  logic                         rst,
   xfer_if.mover                        xfer_p,
   output logic                         mem_req_o,
   output logic                         mem_we_o,
   output logic [dcache_pkg::ADR_W-1:0] mem_adr_o,
   output dcache_pkg::word_t            mem_dat_o,
   input  logic                         mem_ack_i,
   input  dcache_pkg::word_t            mem_dat_i
);

   typedef enum logic [2:0] {M_IDLE, M_WAIT, M_REQ, M_ACK_LOW, M_DONE} mover_state_t;

   mover_state_t         state_q;
   // Word within the line, wraps back to 0 after the last word
   logic [BLOCK_W_P-3:0] cnt_q;

   // ********************
   // Word handshake FSM
   // ********************

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= M_IDLE;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            M_IDLE: begin
               // Write-back needs a RAM read before the first word
               if (xfer_p.start) begin
                  state_q <= xfer_p.dump ? M_WAIT : M_REQ;
               end
            end
            M_WAIT: begin
               state_q <= M_REQ;
            end
            M_REQ: begin
               if (mem_ack_i) begin
                  state_q <= M_ACK_LOW;
               end
            end
            M_ACK_LOW: begin
               // Next word only after memory drops ack
               if (!mem_ack_i) begin
                  cnt_q <= cnt_q + 1'b1;
                  if (&cnt_q) begin
                     state_q <= M_DONE;
                  end else begin
                     state_q <= xfer_p.dump ? M_WAIT : M_REQ;
                  end
               end
            end
            M_DONE: begin
               state_q <= M_IDLE;
            end
            default: begin
               state_q <= M_IDLE;
            end
         endcase
      end
   end

   // ********************
   // Memory port
   // ********************

   assign mem_req_o = (state_q == M_REQ);
   assign mem_we_o  = mem_req_o && xfer_p.dump;
   assign mem_adr_o = {xfer_p.line_adr, cnt_q, 2'b00};
   // Data RAM output, stable while req is high
   assign mem_dat_o = xfer_p.wdata;

   assign xfer_p.word_idx    = cnt_q;
   assign xfer_p.word_strobe = mem_req_o && mem_ack_i && !xfer_p.dump;
   assign xfer_p.rdata       = mem_dat_i;
   assign xfer_p.done        = (state_q == M_DONE);

   // Once raised, a word request is held with the same address and
   // write data until memory answers
   assert property (@(posedge clk) disable iff (rst)
      mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_adr_o)
                                  && (!mem_we_o || $stable(mem_dat_o)))
      else $error("mem_req_o dropped or changed before mem_ack_i");

endmodule

`default_nettype wire

//--- hdl/cache_ctrl.sv
// Cache controller FSM
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         cpu_req_i,
   input  logic                         cpu_we_i,
   input  logic [dcache_pkg::ADR_W-1:0] cpu_adr_i,
   input  dcache_pkg::word_t            cpu_dat_i,
   input  dcache_pkg::bsel_t            cpu_bsel_i,
   output logic                         cpu_ack_o,
   output dcache_pkg::word_t            cpu_dat_o,
   tag_if.ctrl                          tag_p,
   data_if.ctrl                         data_p,
   xfer_if.ctrl                         xfer_p
);
   import dcache_pkg::*;

   ctrl_state_t state_q;
   set_idx_t    req_set;
   tag_t        req_tag;
   word_idx_t   req_word;
   logic        hit;
   logic        in_xfer;
   logic        xfer_busy;

   // Request fields, CPU holds the address while req is high
   assign req_set  = cpu_adr_i[BLOCK_W +: SET_W];
   assign req_tag  = cpu_adr_i[BLOCK_W+SET_W +: TAG_W];
   assign req_word = cpu_adr_i[2 +: WORD_W];

   assign hit     = |tag_p.hit_way;
   assign in_xfer = (state_q == DUMP) || (state_q == REFILL);
   // On the done cycle the data RAM goes back to the request word
   assign xfer_busy = in_xfer && !xfer_p.done;

   // ********************
   // State register
   // ********************

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= IDLE;
      end else begin
         case (state_q)
            IDLE: begin
               // Wait out the tag clear sweep
               if (cpu_req_i && !tag_p.busy) begin
                  state_q <= LOOKUP;
               end
            end
            LOOKUP: begin
               if (hit) begin
                  state_q <= cpu_we_i ? WRITE : DONE;
               end else begin
                  state_q <= tag_p.victim_dirty ? DUMP : REFILL;
               end
            end
            WRITE: begin
               state_q <= DONE;
            end
            DUMP: begin
               if (xfer_p.done) begin
                  state_q <= REFILL;
               end
            end
            // Replay the request as a hit
            REFILL: begin
               if (xfer_p.done) begin
                  state_q <= LOOKUP;
               end
            end
            DONE: begin
               if (!cpu_req_i) begin
                  state_q <= IDLE;
               end
            end
            default: begin
               state_q <= IDLE;
            end
         endcase
      end
   end

   // Read data captured on the hit
   always_ff @(posedge clk) begin
      if (state_q == LOOKUP && hit) begin
         cpu_dat_o <= data_p.rdata;
      end
   end

   assign cpu_ack_o = (state_q == DONE);

   // ********************
   // Tag store
   // ********************

   assign tag_p.set        = req_set;
   assign tag_p.tag        = req_tag;
   assign tag_p.touch      = (state_q == LOOKUP) && hit;
   assign tag_p.mark_dirty = (state_q == WRITE);
   assign tag_p.fill       = (state_q == REFILL) && xfer_p.done;
   // LRU bit is untouched during a miss, so the victim stays put
   assign tag_p.fill_way   = tag_p.victim_way;

   // ********************
   // Data store
   // ********************

   assign data_p.set   = req_set;
   assign data_p.word  = xfer_busy ? xfer_p.word_idx : req_word;
   assign data_p.way   = in_xfer ? tag_p.victim_way : tag_p.hit_way;
   assign data_p.we    = (state_q == WRITE) || ((state_q == REFILL) && xfer_p.word_strobe);
   // Refill words overwrite all bytes
   assign data_p.bsel  = (state_q == WRITE) ? cpu_bsel_i : '1;
   assign data_p.wdata = (state_q == WRITE) ? cpu_dat_i : xfer_p.rdata;

   // ********************
   // Line mover
   // ********************

   assign xfer_p.start    = in_xfer;
   assign xfer_p.dump     = (state_q == DUMP);
   // Write-back goes to the victim's own line
   assign xfer_p.line_adr = {xfer_p.dump ? tag_p.victim_tag : req_tag, req_set};
   assign xfer_p.wdata    = data_p.rdata;

   // Ack must drop one cycle after req is seen low
   assert property (@(posedge clk) disable iff (rst)
      !cpu_req_i && $past(!cpu_req_i) |-> !cpu_ack_o)
      else $error("cpu_ack_o still high after cpu_req_i fell");

endmodule

`default_nettype wire

//--- hdl/dcache_top.sv
// Write-back data cache top
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
   parameter int SET_W_P   = dcache_pkg::SET_W,
   parameter int BLOCK_W_P = dcache_pkg::BLOCK_W
) (
   input  logic                         clk,
   input  logic                         rst,
   // CPU port
   input  logic                         cpu_req_i,
   input  logic                         cpu_we_i,
   input  logic [dcache_pkg::ADR_W-1:0] cpu_adr_i,
   input  dcache_pkg::word_t            cpu_dat_i,
   input  dcache_pkg::bsel_t            cpu_bsel_i,
   output logic                         cpu_ack_o,
   output dcache_pkg::word_t            cpu_dat_o,
   // Memory port, one word per handshake
   output logic                         mem_req_o,
   output logic                         mem_we_o,
   output logic [dcache_pkg::ADR_W-1:0] mem_adr_o,
   output dcache_pkg::word_t            mem_dat_o,
   input  logic                         mem_ack_i,
   input  dcache_pkg::word_t            mem_dat_i
);

   tag_if  tag_bus ();
   data_if data_bus ();
   xfer_if xfer_bus ();

   cache_ctrl u_ctrl (
      .clk        (clk),
      .rst        (rst),
      .cpu_req_i  (cpu_req_i),
      .cpu_we_i   (cpu_we_i),
      .cpu_adr_i  (cpu_adr_i),
      .cpu_dat_i  (cpu_dat_i),
      .cpu_bsel_i (cpu_bsel_i),
      .cpu_ack_o  (cpu_ack_o),
      .cpu_dat_o  (cpu_dat_o),
      .tag_p      (tag_bus.ctrl),
      .data_p     (data_bus.ctrl),
      .xfer_p     (xfer_bus.ctrl)
   );

   tag_store #(
      .SET_W_P (SET_W_P)
   ) u_tags (
      .clk   (clk),
      .rst   (rst),
      .tag_p (tag_bus.store)
   );

   data_store #(
      .SET_W_P   (SET_W_P),
      .BLOCK_W_P (BLOCK_W_P)
   ) u_data (
      .clk    (clk),
      .data_p (data_bus.store)
   );

   line_mover #(
      .BLOCK_W_P (BLOCK_W_P)
   ) u_mover (
      .clk       (clk),
      .rst       (rst),
      .xfer_p    (xfer_bus.mover),
      .mem_req_o (mem_req_o),
      .mem_we_o  (mem_we_o),
      .mem_adr_o (mem_adr_o),
      .mem_dat_o (mem_dat_o),
      .mem_ack_i (mem_ack_i),
      .mem_dat_i (mem_dat_i)
   );

endmodule

`default_nettype wire

//--- verif/tb_dcache.sv
// Data cache testbench
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
   import dcache_pkg::*;

   localparam int    CLK_PERIOD   = 100;
   localparam int    DRIVE_DELAY  = 5;
   localparam int    RESET_CYCLES = 10;
   // Budget per CPU operation, worst case is a dump plus a refill
   localparam int    OP_CYCLES    = 60;
   localparam int    MEM_WORDS    = 2**(ADR_W-2);
   localparam string GOLDEN_FILE  = "verif/dcache_golden.txt";
   localparam logic [31:0] LFSR_SEED = 32'hc5b5a4db;
   // x^32 + x^22 + x^2 + x + 1
   localparam logic [31:0] LFSR_TAPS = 32'h80200003;

   // One line of the golden file
   typedef struct packed {
      logic [7:0]       op;
      logic [ADR_W-1:0] adr;
      word_t            dat;
      bsel_t            bsel;
      word_t            exp_dat;
   } step_t;

   logic             clk;
   logic             rst;
   logic             cpu_req_i;
   logic             cpu_we_i;
   logic [ADR_W-1:0] cpu_adr_i;
   word_t            cpu_dat_i;
   bsel_t            cpu_bsel_i;
   logic             cpu_ack_o;
   word_t            cpu_dat_o;
   logic             mem_req_o;
   logic             mem_we_o;
   logic [ADR_W-1:0] mem_adr_o;
   word_t            mem_dat_o;
   logic             mem_ack_i;
   word_t            mem_dat_i;

   step_t       steps[$];
   int          num_ops      = 0;
   logic        loaded       = 1'b0;
   int          data_errors  = 0;
   int          proto_errors = 0;
   logic [31:0] lfsr_q       = LFSR_SEED;
   logic        prev_cpu_ack;
   logic        prev_cpu_req;
   logic        prev_mem_req;
   logic        prev_mem_ack;
   // Behavioral main memory
   word_t       mem_model [MEM_WORDS];

   dcache_top DUT (
      .clk        (clk),
      .rst        (rst),
      .cpu_req_i  (cpu_req_i),
      .cpu_we_i   (cpu_we_i),
      .cpu_adr_i  (cpu_adr_i),
      .cpu_dat_i  (cpu_dat_i),
      .cpu_bsel_i (cpu_bsel_i),
      .cpu_ack_o  (cpu_ack_o),
      .cpu_dat_o  (cpu_dat_o),
      .mem_req_o  (mem_req_o),
      .mem_we_o   (mem_we_o),
      .mem_adr_o  (mem_adr_o),
      .mem_dat_o  (mem_dat_o),
      .mem_ack_i  (mem_ack_i),
      .mem_dat_i  (mem_dat_i)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   // ********************
   // Helpers
   // ********************

   // Inputs change a little after the rising edge, outputs are settled here
   task automatic next_cycle();
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   // Upper half inverted address, lower half address
   function automatic word_t initial_word(input logic [ADR_W-1:0] adr);
      return {~adr, adr};
   endfunction

   // Galois form, shifts right
   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      logic [31:0] nxt;
      nxt = state >> 1;
      if (state[0]) begin
         nxt = nxt ^ LFSR_TAPS;
      end
      return nxt;
   endfunction

   // One LFSR step per bit
   task automatic take_random_bits(input int count, output int value);
      value = 0;
      for (int i = 0; i < count; i++) begin
         value  = {value[30:0], lfsr_q[0]};
         lfsr_q = lfsr_step(lfsr_q);
      end
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp_val);
      if (got !== exp_val) begin
         data_errors++;
         $display("FAIL %s: got %08h, expected %08h at %0t ns", name, got, exp_val, $time);
      end
   endtask

   task automatic check_handshake(input logic ok, input string what);
      if (!ok) begin
         proto_errors++;
         $display("ERROR: %s at %0t ns", what, $time);
      end
   endtask

   // ********************
   // Golden file
   // ********************

   task automatic load_golden();
      int          fd;
      int          fields;
      string       line;
      logic [7:0]  op;
      logic [31:0] f_adr;
      logic [31:0] f_dat;
      logic [31:0] f_bsel;
      logic [31:0] f_exp;
      step_t       s;
      fd = $fopen(GOLDEN_FILE, "r");
      if (fd == 0) begin
         data_errors++;
         $display("ERROR: cannot open golden file %s", GOLDEN_FILE);
         return;
      end
      while ($fgets(line, fd) != 0) begin
         op     = line.getc(0);
         f_dat  = '0;
         f_bsel = '0;
         if (op == "R" || op == "W") begin
            fields = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h",
                             f_adr, f_dat, f_bsel, f_exp);
            fields = (fields == 4) ? 1 : 0;
         end else if (op == "M") begin
            fields = $sscanf(line.substr(1, line.len() - 1), "%h %h", f_adr, f_exp);
            fields = (fields == 2) ? 1 : 0;
         end else begin
            // Comment or blank line
            continue;
         end
         if (fields == 0) begin
            data_errors++;
            $display("ERROR: malformed golden line: %s", line);
            continue;
         end
         s.op      = op;
         s.adr     = f_adr[ADR_W-1:0];
         s.dat     = f_dat;
         s.bsel    = f_bsel[DAT_W/8-1:0];
         s.exp_dat = f_exp;
         steps.push_back(s);
         if (op != "M") begin
            num_ops++;
         end
      end
      $fclose(fd);
   endtask

   // Full four-phase CPU request
   task automatic run_op(input step_t s);
      cpu_we_i   = (s.op == "W");
      cpu_adr_i  = s.adr;
      cpu_dat_i  = s.dat;
      cpu_bsel_i = s.bsel;
      cpu_req_i  = 1'b1;
      do begin
         next_cycle();
      end while (!cpu_ack_o);
      if (s.op == "R") begin
         check_word($sformatf("cpu_dat_o[%04h]", s.adr), cpu_dat_o, s.exp_dat);
      end
      cpu_req_i = 1'b0;
      next_cycle();
      check_handshake(!cpu_ack_o, "cpu_ack_o did not fall one cycle after cpu_req_i dropped");
   endtask

   // ********************
   // Player
   // ********************

   initial begin : player
      rst        = 1'b1;
      cpu_req_i  = 1'b0;
      cpu_we_i   = 1'b0;
      cpu_adr_i  = '0;
      cpu_dat_i  = '0;
      cpu_bsel_i = '0;
      load_golden();
      loaded = 1'b1;
      repeat (RESET_CYCLES) next_cycle();
      rst = 1'b0;
      foreach (steps[i]) begin
         if (steps[i].op != "M") begin
            run_op(steps[i]);
         end
      end
      // Final memory image, dirty lines only land here on eviction
      foreach (steps[i]) begin
         if (steps[i].op == "M") begin
            check_word($sformatf("mem[%04h]", steps[i].adr),
                       mem_model[steps[i].adr[ADR_W-1:2]], steps[i].exp_dat);
         end
      end
      $display("Errors: %0d data, %0d protocol", data_errors, proto_errors);
      if (data_errors == 0 && proto_errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   // ********************
   // Memory model
   // ********************

   initial begin : memory_model
      int delay;
      mem_ack_i = 1'b0;
      mem_dat_i = '0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem_model[i] = initial_word(ADR_W'(i * 4));
      end
      forever begin
         next_cycle();
         if (mem_req_o && !rst) begin
            // Random back-pressure of 0 to 3 cycles
            take_random_bits(2, delay);
            repeat (delay) next_cycle();
            check_handshake(mem_req_o, "mem_req_o dropped before mem_ack_i rose");
            if (mem_we_o) begin
               mem_model[mem_adr_o[ADR_W-1:2]] = mem_dat_o;
            end else begin
               mem_dat_i = mem_model[mem_adr_o[ADR_W-1:2]];
            end
            mem_ack_i = 1'b1;
            do begin
               next_cycle();
            end while (mem_req_o);
            mem_ack_i = 1'b0;
         end
      end
   end

   // Protocol monitor, samples mid-cycle
   initial begin : monitor
      prev_cpu_ack = 1'b0;
      prev_cpu_req = 1'b0;
      prev_mem_req = 1'b0;
      prev_mem_ack = 1'b0;
      forever begin
         @(negedge clk);
         if (!rst) begin
            // The CPU drops req right after ack, so look at req before the rise
            check_handshake(!(cpu_ack_o && !prev_cpu_ack && !prev_cpu_req),
                            "cpu_ack_o rose without a CPU request");
            check_handshake(!(mem_req_o && !prev_mem_req && prev_mem_ack),
                            "mem_req_o rose while mem_ack_i was still high");
         end
         prev_cpu_ack = cpu_ack_o;
         prev_cpu_req = cpu_req_i;
         prev_mem_req = mem_req_o;
         prev_mem_ack = mem_ack_i;
      end
   end

   // Limit scales with the number of operations in the golden file
   initial begin : watchdog
      int limit;
      wait (loaded);
      limit = RESET_CYCLES + (1 << SET_W) + OP_CYCLES * num_ops;
      repeat (limit) @(posedge clk);
      $display("ERROR: watchdog expired after %0d cycles, a handshake never completed", limit);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

//--- verif/dcache_golden.txt
# R/W lines: op, byte address, write data, byte enables, expected read data (W ignores it)
# M lines: op, byte address, expected final memory word
R 0014 00000000 f ffeb0014
R 001c 00000000 f ffe3001c
W 0018 aabbccdd 3 00000000
W 0010 01020304 f 00000000
W 001c 9a000000 8 00000000
R 0018 00000000 f ffe7ccdd
W 0220 55667788 c 00000000
R 0220 00000000 f 55660220
R 0110 00000000 f feef0110
R 0018 00000000 f ffe7ccdd
R 0210 00000000 f fdef0210
R 0010 00000000 f 01020304
R 0114 00000000 f feeb0114
R 001c 00000000 f 9ae3001c
R 0310 00000000 f fcef0310
R 0414 00000000 f fbeb0414
R 0018 00000000 f ffe7ccdd
M 0010 01020304
M 0014 ffeb0014
M 0018 ffe7ccdd
M 001c 9ae3001c
M 0220 fddf0220

//--- compile.f
hdl/dcache_pkg.sv
hdl/dcache_ifs.sv
hdl/sync_ram.sv
hdl/tag_store.sv
hdl/data_store.sv
hdl/line_mover.sv
hdl/cache_ctrl.sv
hdl/dcache_top.sv
verif/tb_dcache.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --top-module tb_dcache -f compile.f \
   -o tb_dcache > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
   echo "Verilator build failed, see $BUILD_LOG"
   exit 1
fi

./obj_dir/tb_dcache > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$SIM_LOG"; then
   exit 1
fi
exit 0
